//--- Bender.yml
package:
  name: vga_fb

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wb_pkg.sv
      - hdl/vga_pixel_pkg.sv
      - hdl/vga_regs.sv
      - hdl/vga_line_fetch.sv
      - hdl/vga_line_buffer.sv
      - hdl/vga_scanout.sv
      - hdl/vga_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - verif/wb_mem_model.sv
      - verif/vga_tb.sv

//--- hdl/vga_config.svh
`ifndef VGA_CONFIG_SVH
`define VGA_CONFIG_SVH

// horizontal timing in clocks, active area first
`define VGA_H_ACTIVE 16
`define VGA_H_FRONT  4
`define VGA_H_SYNC   8
`define VGA_H_BACK   36
`define VGA_H_TOTAL  (`VGA_H_ACTIVE + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK)

// vertical timing in lines
`define VGA_V_ACTIVE 4
`define VGA_V_FRONT  1
`define VGA_V_SYNC   2
`define VGA_V_BACK   1
`define VGA_V_TOTAL  (`VGA_V_ACTIVE + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK)

// slave word offsets, palette sits below 9'h100
`define VGA_REG_BASE 9'h100
`define VGA_REG_MODE 9'h101

`define VGA_BASE_RESET 32'h0000_1000

`endif

//--- hdl/vga_line_buffer.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_line_buffer (
  input  logic                clk_i,
  input  logic                wr_en_i,
  input  logic                wr_bank_i,
  input  logic [3:0]          wr_addr_i,
  input  vga_pixel_pkg::rgb_t wr_rgb_i,
  input  logic                rd_bank_i,
  input  logic [3:0]          rd_addr_i,
  output vga_pixel_pkg::rgb_t rd_rgb_o
);

  // bank select is the top address bit
  vga_pixel_pkg::rgb_t mem [2 * `VGA_H_ACTIVE];

  always_ff @(posedge clk_i) begin
    if (wr_en_i)
      mem[{wr_bank_i, wr_addr_i}] <= wr_rgb_i;
  end

  always_ff @(posedge clk_i) begin
    rd_rgb_o <= mem[{rd_bank_i, rd_addr_i}];
  end

endmodule

//--- hdl/vga_line_fetch.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_line_fetch (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  vga_pixel_pkg::line_req_t req_i,
  input  logic                     bank_i,
  input  logic [31:0]              base_i,
  input  vga_pixel_pkg::mode_reg_t mode_i,
  output wb_pkg::wb_m2s_t          wb_o,
  input  wb_pkg::wb_s2m_t          wb_i,
  output logic [7:0]               pal_idx_o,
  input  vga_pixel_pkg::rgb_t      pal_rgb_i,
  output logic                     wr_en_o,
  output logic                     wr_bank_o,
  output logic [3:0]               wr_addr_o,
  output vga_pixel_pkg::rgb_t      wr_rgb_o
);

  localparam int WORDS = `VGA_H_ACTIVE / 4;

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUS,
    S_LOOKUP,
    S_STORE
  } fetch_state_t;

  fetch_state_t state_q;
  logic         pend_q;
  logic [9:0]   pend_line_q;
  logic         pend_bank_q;
  logic [31:0]  line_adr_q;
  logic         bank_q;
  logic         black_q;
  logic         dbl_q;
  logic [1:0]   word_q;
  logic [1:0]   pix_q;
  logic [31:0]  idx_sr_q;
  logic         start;
  logic         last_word;

  assign start = (state_q == S_IDLE) && pend_q;
  // a doubled source line is half as long, a black line always covers the full width
  assign last_word = (dbl_q && !black_q) ? (word_q == 2'(WORDS/2 - 1))
                                         : (word_q == 2'(WORDS - 1));

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      pend_q  <= 1'b0;
      black_q <= 1'b0;
      dbl_q   <= 1'b0;
      word_q  <= '0;
      pix_q   <= '0;
    end else begin
      if (req_i.valid)
        pend_q <= 1'b1;
      else if (start)
        pend_q <= 1'b0;

      case (state_q)
        S_IDLE: begin
          if (start) begin
            word_q  <= '0;
            pix_q   <= '0;
            black_q <= !mode_i.enable;
            dbl_q   <= mode_i.double_en;
            state_q <= mode_i.enable ? S_BUS : S_STORE;
          end
        end
        S_BUS: begin
          if (wb_i.ack)
            state_q <= S_LOOKUP;
        end
        S_LOOKUP: begin
          pix_q   <= '0;
          state_q <= S_STORE;
        end
        S_STORE: begin
          pix_q <= pix_q + 2'd1;
          if (pix_q == 2'd3) begin
            if (last_word) begin
              state_q <= S_IDLE;
            end else begin
              word_q  <= word_q + 2'd1;
              state_q <= black_q ? S_STORE : S_BUS;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      pend_line_q <= req_i.line_num;
      pend_bank_q <= bank_i;
    end
    if (start) begin
      bank_q <= pend_bank_q;
      if (mode_i.double_en)
        line_adr_q <= base_i + 32'(pend_line_q) * (`VGA_H_ACTIVE / 2);
      else
        line_adr_q <= base_i + 32'(pend_line_q) * `VGA_H_ACTIVE;
    end
    // indices leave from the top byte, one per clock
    if (state_q == S_BUS && wb_i.ack)
      idx_sr_q <= wb_i.dat;
    else if (state_q == S_LOOKUP || state_q == S_STORE)
      idx_sr_q <= idx_sr_q << 8;
  end

  always_comb begin
    wb_o     = '0;
    wb_o.adr = line_adr_q + (32'(word_q) << 2);
    wb_o.sel = 4'hf;
    wb_o.cyc = (state_q == S_BUS);
    wb_o.stb = (state_q == S_BUS);
  end

  // palette answers one clock later, so store lags the index by one
  assign pal_idx_o = idx_sr_q[31:24];
  assign wr_en_o   = (state_q == S_STORE);
  assign wr_bank_o = bank_q;
  assign wr_addr_o = {word_q, pix_q};
  assign wr_rgb_o  = black_q ? '0 : pal_rgb_i;

endmodule

//--- hdl/vga_pixel_pkg.sv
package vga_pixel_pkg;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef struct packed {
    logic [29:0] reserved;
    logic        double_en;
    logic        enable;
  } mode_reg_t;

  // palette view of a slave write word
  typedef struct packed {
    logic [7:0] unused;
    rgb_t       rgb;
  } pal_word_t;

  // one write word, decoded by target address
  typedef union packed {
    pal_word_t pal;
    mode_reg_t mode;
  } cfg_word_u;

  // line number is in source lines, already halved in double mode
  typedef struct packed {
    logic       valid;
    logic [9:0] line_num;
  } line_req_t;

endpackage

//--- hdl/vga_regs.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_regs (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  wb_pkg::wb_m2s_t          wb_i,
  output wb_pkg::wb_s2m_t          wb_o,
  input  logic [7:0]               pal_idx_i,
  output vga_pixel_pkg::rgb_t      pal_rgb_o,
  output logic [31:0]              base_o,
  output vga_pixel_pkg::mode_reg_t mode_o
);

  typedef enum logic {
    S_IDLE,
    S_ACK
  } ack_state_t;

  ack_state_t                state_q;
  logic [31:0]               base_q;
  vga_pixel_pkg::mode_reg_t  mode_q;
  logic [31:0]               rdat_q;
  vga_pixel_pkg::rgb_t       pal_mem [256];
  vga_pixel_pkg::cfg_word_u  wdat;
  logic [8:0]                adr;
  logic                      req;
  logic                      wr;

  assign adr  = wb_i.adr[8:0];
  assign wdat = wb_i.dat;
  // a request is only taken in idle, so the ack cycle never samples
  assign req  = (state_q == S_IDLE) && wb_i.cyc && wb_i.stb;
  assign wr   = req && wb_i.we;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      base_q  <= `VGA_BASE_RESET;
      mode_q  <= '0;
      rdat_q  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req) begin
            state_q <= S_ACK;
            rdat_q  <= '0;
            if (wb_i.we) begin
              if (adr == `VGA_REG_BASE) begin
                for (int i = 0; i < 4; i++) begin
                  if (wb_i.sel[i])
                    base_q[8*i +: 8] <= wb_i.dat[8*i +: 8];
                end
              end
              // only the low byte holds mode bits
              if (adr == `VGA_REG_MODE && wb_i.sel[0]) begin
                mode_q.enable    <= wdat.mode.enable;
                mode_q.double_en <= wdat.mode.double_en;
              end
            end else begin
              case (adr)
                `VGA_REG_BASE: rdat_q <= base_q;
                `VGA_REG_MODE: rdat_q <= mode_q;
                default:       rdat_q <= '0;
              endcase
            end
          end
        end
        S_ACK: state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // palette, write-only from the bus
  always_ff @(posedge clk_i) begin
    if (wr && !adr[8])
      pal_mem[adr[7:0]] <= wdat.pal.rgb;
    pal_rgb_o <= pal_mem[pal_idx_i];
  end

  assign wb_o.dat = rdat_q;
  assign wb_o.ack = (state_q == S_ACK);
  assign base_o   = base_q;
  assign mode_o   = mode_q;

endmodule

//--- hdl/vga_scanout.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_scanout (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  vga_pixel_pkg::mode_reg_t mode_i,
  output vga_pixel_pkg::line_req_t req_o,
  output logic                     bank_o,
  output logic                     rd_bank_o,
  output logic [3:0]               rd_addr_o,
  input  vga_pixel_pkg::rgb_t      rd_rgb_i,
  output logic                     hs_o,
  output logic                     vs_o,
  output logic                     blank_n_o,
  output vga_pixel_pkg::rgb_t      rgb_o
);

  localparam int H_TOTAL  = `VGA_H_TOTAL;
  localparam int V_TOTAL  = `VGA_V_TOTAL;
  localparam int HS_START = `VGA_H_ACTIVE + `VGA_H_FRONT;
  localparam int VS_START = `VGA_V_ACTIVE + `VGA_V_FRONT;

  logic [$clog2(H_TOTAL)-1:0] h_cnt_q;
  logic [$clog2(V_TOTAL)-1:0] v_cnt_q;
  logic [9:0]                 next_y;
  logic                       hs_n;
  logic                       vs_n;
  logic                       active;
  logic                       hs_d;
  logic                       vs_d;
  logic                       act_d;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      h_cnt_q <= '0;
      v_cnt_q <= '0;
    end else if (h_cnt_q == H_TOTAL - 1) begin
      h_cnt_q <= '0;
      v_cnt_q <= (v_cnt_q == V_TOTAL - 1) ? '0 : v_cnt_q + 1'b1;
    end else begin
      h_cnt_q <= h_cnt_q + 1'b1;
    end
  end

  assign hs_n   = !(h_cnt_q >= HS_START && h_cnt_q < HS_START + `VGA_H_SYNC);
  assign vs_n   = !(v_cnt_q >= VS_START && v_cnt_q < VS_START + `VGA_V_SYNC);
  assign active = (h_cnt_q < `VGA_H_ACTIVE) && (v_cnt_q < `VGA_V_ACTIVE);

  // request the following visible line one line ahead
  assign next_y = (v_cnt_q == V_TOTAL - 1) ? '0 : 10'(v_cnt_q) + 10'd1;
  assign req_o.valid = (h_cnt_q == 0) &&
                       (v_cnt_q == V_TOTAL - 1 || v_cnt_q < `VGA_V_ACTIVE - 1);
  assign req_o.line_num = mode_i.double_en ? (next_y >> 1) : next_y;
  assign bank_o = next_y[0];

  assign rd_bank_o = v_cnt_q[0];
  assign rd_addr_o = mode_i.double_en ? 4'(h_cnt_q >> 1) : 4'(h_cnt_q);

  // stage one waits for the buffer read, stage two drives the pins
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      hs_d      <= 1'b1;
      vs_d      <= 1'b1;
      act_d     <= 1'b0;
      hs_o      <= 1'b1;
      vs_o      <= 1'b1;
      blank_n_o <= 1'b0;
      rgb_o     <= '0;
    end else begin
      hs_d      <= hs_n;
      vs_d      <= vs_n;
      act_d     <= active;
      hs_o      <= hs_d;
      vs_o      <= vs_d;
      blank_n_o <= act_d;
      rgb_o     <= act_d ? rd_rgb_i : '0;
    end
  end

endmodule

//--- hdl/vga_top.sv
`timescale 1ns/1ps

module vga_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  wb_pkg::wb_m2s_t     wbs_i,
  output wb_pkg::wb_s2m_t     wbs_o,
  output wb_pkg::wb_m2s_t     wbm_o,
  input  wb_pkg::wb_s2m_t     wbm_i,
  output logic                hs_o,
  output logic                vs_o,
  output logic                blank_n_o,
  output vga_pixel_pkg::rgb_t rgb_o
);

  logic [31:0]              base;
  vga_pixel_pkg::mode_reg_t mode;
  logic [7:0]               pal_idx;
  vga_pixel_pkg::rgb_t      pal_rgb;
  vga_pixel_pkg::line_req_t line_req;
  logic                     req_bank;
  logic                     wr_en;
  logic                     wr_bank;
  logic [3:0]               wr_addr;
  vga_pixel_pkg::rgb_t      wr_rgb;
  logic                     rd_bank;
  logic [3:0]               rd_addr;
  vga_pixel_pkg::rgb_t      rd_rgb;

  vga_regs regs0 (
    .clk_i(clk_i), .rst_i(rst_i), .wb_i(wbs_i), .wb_o(wbs_o),
    .pal_idx_i(pal_idx), .pal_rgb_o(pal_rgb), .base_o(base), .mode_o(mode)
  );

  vga_line_fetch fetch0 (
    .clk_i(clk_i), .rst_i(rst_i), .req_i(line_req), .bank_i(req_bank),
    .base_i(base), .mode_i(mode), .wb_o(wbm_o), .wb_i(wbm_i),
    .pal_idx_o(pal_idx), .pal_rgb_i(pal_rgb), .wr_en_o(wr_en),
    .wr_bank_o(wr_bank), .wr_addr_o(wr_addr), .wr_rgb_o(wr_rgb)
  );

  vga_line_buffer lbuf0 (
    .clk_i(clk_i), .wr_en_i(wr_en), .wr_bank_i(wr_bank), .wr_addr_i(wr_addr),
    .wr_rgb_i(wr_rgb), .rd_bank_i(rd_bank), .rd_addr_i(rd_addr), .rd_rgb_o(rd_rgb)
  );

  vga_scanout scan0 (
    .clk_i(clk_i), .rst_i(rst_i), .mode_i(mode), .req_o(line_req), .bank_o(req_bank),
    .rd_bank_o(rd_bank), .rd_addr_o(rd_addr), .rd_rgb_i(rd_rgb),
    .hs_o(hs_o), .vs_o(vs_o), .blank_n_o(blank_n_o), .rgb_o(rgb_o)
  );

endmodule

//--- hdl/wb_pkg.sv
package wb_pkg;

  // master to slave, classic cycles only
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    logic        cyc;
    logic        stb;
  } wb_m2s_t;

  // slave to master
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
  } wb_s2m_t;

endpackage

//--- tb.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/vga_pixel_pkg.sv
hdl/vga_regs.sv
hdl/vga_line_fetch.sv
hdl/vga_line_buffer.sv
hdl/vga_scanout.sv
hdl/vga_top.sv
verif/wb_mem_model.sv
verif/vga_tb.sv

//--- verif/vga_tb.sv
`timescale 1ns/1ps
`include "vga_config.svh"

module vga_tb;

  localparam int N_TESTS     = 5;
  localparam int CLK_NS      = 20;
  localparam int FRAME_CYC   = `VGA_H_TOTAL * `VGA_V_TOTAL;
  localparam int N_ACTIVE    = `VGA_H_ACTIVE * `VGA_V_ACTIVE;
  localparam int WATCHDOG_NS = (N_TESTS * 3 + 8) * FRAME_CYC * CLK_NS;

  logic                clk_i;
  logic                rst_i;
  wb_pkg::wb_m2s_t     wbs_m2s;
  wb_pkg::wb_s2m_t     wbs_s2m;
  wb_pkg::wb_m2s_t     wbm_m2s;
  wb_pkg::wb_s2m_t     wbm_s2m;
  logic                hs;
  logic                vs;
  logic                blank_n;
  vga_pixel_pkg::rgb_t rgb;

  integer              seed;
  logic [23:0]         pal [256];
  logic [31:0]         base_ref;

  // one captured frame sampled on falling edges
  logic                cap_blank [FRAME_CYC];
  logic                cap_hs [FRAME_CYC];
  logic                cap_vs [FRAME_CYC];
  logic [23:0]         cap_rgb [FRAME_CYC];
  int                  cap_cyc;

  vga_top dut0 (
    .clk_i(clk_i), .rst_i(rst_i), .wbs_i(wbs_m2s), .wbs_o(wbs_s2m),
    .wbm_o(wbm_m2s), .wbm_i(wbm_s2m), .hs_o(hs), .vs_o(vs),
    .blank_n_o(blank_n), .rgb_o(rgb)
  );

  wb_mem_model mem0 (
    .clk_i(clk_i), .rst_i(rst_i), .wb_i(wbm_m2s), .wb_o(wbm_s2m)
  );

  always #(CLK_NS / 2) clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      report_failure($sformatf("error at %0t ns: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic wb_access(input logic we, input logic [8:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic [31:0] rdat);
    int wait_cyc;
    @(negedge clk_i);
    wbs_m2s.adr = 32'(adr);
    wbs_m2s.dat = dat;
    wbs_m2s.sel = sel;
    wbs_m2s.we  = we;
    wbs_m2s.cyc = 1'b1;
    wbs_m2s.stb = 1'b1;
    wait_cyc = 0;
    do begin
      @(negedge clk_i);
      wait_cyc++;
      if (wait_cyc > 16)
        report_failure("slave port gave no acknowledge within 16 cycles");
    end while (!wbs_s2m.ack);
    rdat = wbs_s2m.dat;
    // request stays up through the ack edge and drops after it
    @(negedge clk_i);
    wbs_m2s = '0;
    check("wbs_o.ack after ack cycle", 32'd0, 32'(wbs_s2m.ack));
  endtask

  task automatic wb_write(input logic [8:0] adr, input logic [31:0] dat, input logic [3:0] sel);
    logic [31:0] unused;
    wb_access(1'b1, adr, dat, sel, unused);
  endtask

  task automatic wb_read(input logic [8:0] adr, output logic [31:0] dat);
    wb_access(1'b0, adr, 32'd0, 4'hf, dat);
  endtask

  function automatic logic [7:0] mem_byte(input logic [31:0] addr);
    logic [31:0] word;
    word = mem0.mem[addr[9:2]];
    // first pixel of a word is the top byte
    return word[8*(3 - addr[1:0]) +: 8];
  endfunction

  // the end of vsync is a fixed point in the frame
  task automatic wait_frame_start();
    do @(negedge clk_i); while (vs !== 1'b0);
    do @(negedge clk_i); while (vs !== 1'b1);
  endtask

  task automatic capture_frame();
    wait_frame_start();
    cap_cyc = 0;
    for (int i = 0; i < FRAME_CYC; i++) begin
      if (i > 0)
        @(negedge clk_i);
      cap_blank[i] = blank_n;
      cap_hs[i]    = hs;
      cap_vs[i]    = vs;
      cap_rgb[i]   = rgb;
      if (wbm_m2s.cyc) begin
        cap_cyc++;
        check("wbm_o.stb", 32'd1, 32'(wbm_m2s.stb));
        check("wbm_o.we", 32'd0, 32'(wbm_m2s.we));
        check("wbm_o.sel", 32'hf, 32'(wbm_m2s.sel));
      end
    end
  endtask

  task automatic check_frame_structure();
    int hs_pulses;
    int hs_run;
    int vs_low;
    int active;
    hs_pulses = 0;
    hs_run = 0;
    vs_low = 0;
    active = 0;
    for (int i = 0; i < FRAME_CYC; i++) begin
      if (!cap_hs[i]) begin
        if (hs_run == 0)
          hs_pulses++;
        hs_run++;
      end else if (hs_run != 0) begin
        check("hs_o pulse width", `VGA_H_SYNC, hs_run);
        hs_run = 0;
      end
      if (!cap_vs[i])
        vs_low++;
      if (cap_blank[i])
        active++;
      else
        check("rgb_o in blanking", 32'd0, 32'(cap_rgb[i]));
    end
    check("hs_o low pulses", `VGA_V_TOTAL, hs_pulses);
    check("vs_o low cycles", `VGA_V_SYNC * `VGA_H_TOTAL, vs_low);
    check("blank_n_o high cycles", N_ACTIVE, active);
  endtask

  task automatic check_active_pixels(input logic dbl, input logic black);
    int          k;
    int          x;
    int          y;
    logic [31:0] addr;
    logic [23:0] exp;
    k = 0;
    for (int i = 0; i < FRAME_CYC; i++) begin
      if (cap_blank[i]) begin
        x = k % `VGA_H_ACTIVE;
        y = k / `VGA_H_ACTIVE;
        if (dbl)
          addr = base_ref + 32'((y / 2) * (`VGA_H_ACTIVE / 2) + x / 2);
        else
          addr = base_ref + 32'(y * `VGA_H_ACTIVE + x);
        exp = black ? 24'h0 : pal[mem_byte(addr)];
        check($sformatf("rgb_o at x %0d y %0d", x, y), 32'(exp), 32'(cap_rgb[i]));
        k++;
      end
    end
  endtask

  task automatic test_registers();
    logic [31:0] rd;
    wb_read(`VGA_REG_BASE, rd);
    check("base after reset", `VGA_BASE_RESET, rd);
    wb_read(`VGA_REG_MODE, rd);
    check("mode after reset", 32'd0, rd);
    wb_write(`VGA_REG_BASE, 32'hAABB_CCDD, 4'b0101);
    wb_read(`VGA_REG_BASE, rd);
    // bytes 0 and 2 are new, bytes 1 and 3 keep the reset value
    check("base after byte write", 32'h00BB_10DD, rd);
    // mode bits live in byte 0 only
    wb_write(`VGA_REG_MODE, 32'h0000_0003, 4'b1110);
    wb_read(`VGA_REG_MODE, rd);
    check("mode with byte 0 unselected", 32'd0, rd);
    wb_write(`VGA_REG_MODE, 32'h0000_0002, 4'b0001);
    wb_read(`VGA_REG_MODE, rd);
    check("mode after byte 0 write", 32'h0000_0002, rd);
    wb_write(`VGA_REG_MODE, 32'd0, 4'hf);
    wb_write(9'h005, 32'h0012_3456, 4'hf);
    wb_read(9'h005, rd);
    check("palette read", 32'd0, rd);
    wb_read(9'h102, rd);
    check("unmapped read 102", 32'd0, rd);
    wb_read(9'h1ff, rd);
    check("unmapped read 1ff", 32'd0, rd);
  endtask

  task automatic test_normal_frame();
    logic [31:0] data;
    for (int i = 0; i < 256; i++) begin
      data = $random(seed);
      pal[i] = data[23:0];
      wb_write(9'(i), data, 4'hf);
    end
    base_ref = 32'h0000_1080;
    wb_write(`VGA_REG_BASE, base_ref, 4'hf);
    wb_write(`VGA_REG_MODE, 32'h0000_0001, 4'hf);
    wait_frame_start();
    capture_frame();
    check_active_pixels(1'b0, 1'b0);
  endtask

  task automatic test_frame_structure();
    capture_frame();
    check_frame_structure();
    check_active_pixels(1'b0, 1'b0);
  endtask

  task automatic test_double_frame();
    base_ref = 32'h0000_1200;
    wb_write(`VGA_REG_BASE, base_ref, 4'hf);
    wb_write(`VGA_REG_MODE, 32'h0000_0003, 4'hf);
    wait_frame_start();
    capture_frame();
    check_frame_structure();
    check_active_pixels(1'b1, 1'b0);
  endtask

  task automatic test_disabled();
    wb_write(`VGA_REG_MODE, 32'd0, 4'hf);
    wait_frame_start();
    capture_frame();
    check("master cyc_o cycles", 32'd0, cap_cyc);
    check_frame_structure();
    check_active_pixels(1'b0, 1'b1);
  endtask

  initial begin
    seed = 32'h6c4d;
    clk_i = 1'b0;
    rst_i = 1'b1;
    wbs_m2s = '0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    test_registers();
    test_normal_frame();
    test_frame_structure();
    test_double_frame();
    test_disabled();
    $display("Simulation PASSED");
    $finish;
  end

  // three frames per test plus margin
  initial begin
    #(WATCHDOG_NS);
    report_failure("timeout: the tests did not finish in the allowed time");
  end

endmodule

//--- verif/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
  input  logic            clk_i,
  input  logic            rst_i,
  input  wb_pkg::wb_m2s_t wb_i,
  output wb_pkg::wb_s2m_t wb_o
);

  // read-only pixel store, word index from adr[9:2]
  logic [31:0] mem [256];
  integer      seed;
  logic        busy_q;
  logic [1:0]  wait_q;

  initial begin
    seed = 32'h6c4d;
    for (int i = 0; i < 256; i++)
      mem[i] = $random(seed);
  end

  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wb_o   <= '0;
      busy_q <= 1'b0;
      wait_q <= '0;
    end else begin
      wb_o.ack <= 1'b0;
      if (wb_i.cyc && wb_i.stb && !wb_o.ack) begin
        if (!busy_q) begin
          // draw 0 to 3 wait cycles for this access
          busy_q <= 1'b1;
          wait_q <= 2'($random(seed));
        end else if (wait_q == 2'd0) begin
          busy_q   <= 1'b0;
          wb_o.ack <= 1'b1;
          wb_o.dat <= mem[wb_i.adr[9:2]];
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

endmodule
